// ==== source/isa_pkg.sv ====
package isa_pkg;

  typedef logic [4:0] reg_addr_t;

  // primary opcodes
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_addi  = 6'h08,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_xori  = 6'h0e
  } opcode_e;

  // function codes, register format only
  typedef enum logic [5:0] {
    f_sll = 6'h00,
    f_srl = 6'h02,
    f_add = 6'h20,
    f_sub = 6'h22,
    f_and = 6'h24,
    f_or  = 6'h25,
    f_xor = 6'h26,
    f_slt = 6'h2a
  } funct_e;

  typedef struct packed {
    opcode_e    opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    funct_e     funct;
  } instr_r_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } instr_i_t;

  // same word, two views
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_sll = 4'd6,
    alu_srl = 4'd7
  } alu_op_e;

  // decoded control, carried from decode into execute
  typedef struct packed {
    alu_op_e            alu_op;
    logic               use_imm;
    logic               reg_write;
    isa_pkg::reg_addr_t dest;
    logic [4:0]         shamt;
  } ctrl_t;

  // writeback report of one lane
  typedef struct packed {
    logic               valid;
    isa_pkg::reg_addr_t dest;
  } wb_t;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
  import isa_pkg::*, pipe_pkg::*;
(
  input  instr_u instr,
  output ctrl_t  ctrl,
  output logic   valid_op
);

  always_comb begin
    ctrl       = '0;
    valid_op   = 1'b1;
    ctrl.shamt = instr.r.shamt;

    if (instr.r.opcode == op_rtype) begin
      // register format, result goes to rd
      ctrl.use_imm = 1'b0;
      ctrl.dest    = instr.r.rd;
      case (instr.r.funct)
        f_add:   ctrl.alu_op = alu_add;
        f_sub:   ctrl.alu_op = alu_sub;
        f_and:   ctrl.alu_op = alu_and;
        f_or:    ctrl.alu_op = alu_or;
        f_xor:   ctrl.alu_op = alu_xor;
        f_slt:   ctrl.alu_op = alu_slt;
        f_sll:   ctrl.alu_op = alu_sll;
        f_srl:   ctrl.alu_op = alu_srl;
        default: begin
          ctrl.alu_op = alu_add;
          valid_op    = 1'b0;
        end
      endcase
    end else begin
      // immediate format, result goes to rt
      ctrl.use_imm = 1'b1;
      ctrl.dest    = instr.i.rt;
      case (instr.i.opcode)
        op_addi: ctrl.alu_op = alu_add;
        op_andi: ctrl.alu_op = alu_and;
        op_ori:  ctrl.alu_op = alu_or;
        op_xori: ctrl.alu_op = alu_xor;
        default: begin
          ctrl.alu_op = alu_add;
          valid_op    = 1'b0;
        end
      endcase
    end

    // r0 is hardwired, never written
    ctrl.reg_write = valid_op && (ctrl.dest != '0);
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
  import pipe_pkg::*;
#(
  parameter int data_width = 32
) (
  input  alu_op_e               op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  logic [4:0]            shamt,
  output logic [data_width-1:0] result
);

  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = data_width'(less);
      // shifts act on the rt operand
      alu_sll: result = b << shamt;
      alu_srl: result = b >> shamt;
      default: result = '0;
    endcase
  end

endmodule

// ==== source/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  issue,
  input  instr_u                instr,
  input  logic [data_width-1:0] rs_data,
  input  logic [data_width-1:0] rt_data,
  input  wb_t                   peer_wb,
  input  logic [data_width-1:0] peer_data,
  input  logic                  older,
  output reg_addr_t             rs_addr,
  output reg_addr_t             rt_addr,
  output wb_t                   wb,
  output logic [data_width-1:0] wb_data
);

  ctrl_t                 dec_ctrl;
  logic                  dec_valid_op;

  logic                  ex_valid;
  ctrl_t                 ex_ctrl;
  reg_addr_t             ex_rs;
  reg_addr_t             ex_rt;
  logic [data_width-1:0] ex_rs_data;
  logic [data_width-1:0] ex_rt_data;
  logic [15:0]           ex_imm;

  logic [data_width-1:0] op_a;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_b;
  logic [data_width-1:0] alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // decode

  assign rs_addr = instr.r.rs;
  assign rt_addr = instr.r.rt;

  instr_decoder u_decoder (
    .instr    (instr),
    .ctrl     (dec_ctrl),
    .valid_op (dec_valid_op)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
      ex_ctrl  <= '0;
    end else begin
      ex_valid <= issue && dec_valid_op;
      ex_ctrl  <= dec_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs      <= instr.r.rs;
    ex_rt      <= instr.r.rt;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_imm     <= instr.i.imm;
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute

  // lane 1 result outranks lane 0 when both hit
  function automatic logic [data_width-1:0] fwd(reg_addr_t src,
                                                logic [data_width-1:0] dflt);
    logic own_hit;
    logic peer_hit;
    own_hit  = wb.valid && (wb.dest == src);
    peer_hit = peer_wb.valid && (peer_wb.dest == src);
    if (own_hit && !(peer_hit && older))
      return wb_data;
    else if (peer_hit)
      return peer_data;
    else
      return dflt;
  endfunction

  always_comb begin
    op_a = fwd(ex_rs, ex_rs_data);
    op_b = fwd(ex_rt, ex_rt_data);
  end

  // immediates are zero extended
  assign alu_b = ex_ctrl.use_imm ? data_width'(ex_imm) : op_b;

  alu #(
    .data_width (data_width)
  ) u_alu (
    .op     (ex_ctrl.alu_op),
    .a      (op_a),
    .b      (alu_b),
    .shamt  (ex_ctrl.shamt),
    .result (alu_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // writeback

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else begin
      wb.valid <= ex_valid && ex_ctrl.reg_write;
      wb.dest  <= ex_ctrl.dest;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= alu_result;
  end

  assert property (@(posedge clk) disable iff (!arst_n) wb.valid |-> (wb.dest != '0))
    else $error("writeback reported for r0");

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  reg_addr_t             rs_addr0,
  input  reg_addr_t             rt_addr0,
  input  reg_addr_t             rs_addr1,
  input  reg_addr_t             rt_addr1,
  input  wb_t                   wb0,
  input  wb_t                   wb1,
  input  logic [data_width-1:0] wb_data0,
  input  logic [data_width-1:0] wb_data1,
  output logic [data_width-1:0] rs_data0,
  output logic [data_width-1:0] rt_data0,
  output logic [data_width-1:0] rs_data1,
  output logic [data_width-1:0] rt_data1
);

  logic [data_width-1:0] regs [32];

  // lane 1 written last so it wins a shared dest
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0.valid) regs[wb0.dest] <= wb_data0;
      if (wb1.valid) regs[wb1.dest] <= wb_data1;
    end
  end

  // write-through, same priority as the write
  function automatic logic [data_width-1:0] read_port(reg_addr_t addr);
    logic [data_width-1:0] data;
    data = regs[addr];
    if (wb0.valid && (wb0.dest == addr)) data = wb_data0;
    if (wb1.valid && (wb1.dest == addr)) data = wb_data1;
    return data;
  endfunction

  always_comb begin
    rs_data0 = read_port(rs_addr0);
    rt_data0 = read_port(rt_addr0);
    rs_data1 = read_port(rs_addr1);
    rt_data1 = read_port(rt_addr1);
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    !(wb0.valid && (wb0.dest == '0)) && !(wb1.valid && (wb1.dest == '0)))
    else $error("write to r0");

endmodule

// ==== source/dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  issue,
  input  instr_u                instr0,
  input  instr_u                instr1,
  output wb_t                   wb0,
  output wb_t                   wb1,
  output logic [data_width-1:0] wb_data0,
  output logic [data_width-1:0] wb_data1
);

  reg_addr_t             rs_addr0;
  reg_addr_t             rt_addr0;
  reg_addr_t             rs_addr1;
  reg_addr_t             rt_addr1;
  logic [data_width-1:0] rs_data0;
  logic [data_width-1:0] rt_data0;
  logic [data_width-1:0] rs_data1;
  logic [data_width-1:0] rt_data1;

  // lane 0 holds the older instruction of the pair
  exec_lane #(
    .data_width (data_width)
  ) u_lane0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .instr     (instr0),
    .rs_data   (rs_data0),
    .rt_data   (rt_data0),
    .peer_wb   (wb1),
    .peer_data (wb_data1),
    .older     (1'b1),
    .rs_addr   (rs_addr0),
    .rt_addr   (rt_addr0),
    .wb        (wb0),
    .wb_data   (wb_data0)
  );

  exec_lane #(
    .data_width (data_width)
  ) u_lane1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .instr     (instr1),
    .rs_data   (rs_data1),
    .rt_data   (rt_data1),
    .peer_wb   (wb0),
    .peer_data (wb_data0),
    .older     (1'b0),
    .rs_addr   (rs_addr1),
    .rt_addr   (rt_addr1),
    .wb        (wb1),
    .wb_data   (wb_data1)
  );

  register_file #(
    .data_width (data_width)
  ) u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs_addr0 (rs_addr0),
    .rt_addr0 (rt_addr0),
    .rs_addr1 (rs_addr1),
    .rt_addr1 (rt_addr1),
    .wb0      (wb0),
    .wb1      (wb1),
    .wb_data0 (wb_data0),
    .wb_data1 (wb_data1),
    .rs_data0 (rs_data0),
    .rt_data0 (rt_data0),
    .rs_data1 (rs_data1),
    .rt_data1 (rt_data1)
  );

endmodule

// ==== sim/dual_issue_core_tb.sv ====
`timescale 1ns/1ps

module dual_issue_core_tb
  import isa_pkg::*, pipe_pkg::*;
();

  localparam int data_width = 32;
  localparam int max_cases  = 64;

  typedef struct packed {
    logic        valid;
    logic [4:0]  dest;
    logic [31:0] data;
  } exp_wb_t;

  logic                  clk;
  logic                  arst_n;
  logic                  issue;
  instr_u                instr0;
  instr_u                instr1;
  wb_t                   wb0;
  wb_t                   wb1;
  logic [data_width-1:0] wb_data0;
  logic [data_width-1:0] wb_data1;

  string       case_name  [max_cases];
  logic [31:0] case_instr0 [max_cases];
  logic [31:0] case_instr1 [max_cases];
  exp_wb_t     case_exp0  [max_cases];
  exp_wb_t     case_exp1  [max_cases];
  int          n_cases;
  int          pass_count;
  int          fail_count;
  int          idle_errors;
  int          load_errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] lcg_state;

  dual_issue_core #(
    .data_width (data_width)
  ) u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (issue),
    .instr0   (instr0),
    .instr1   (instr1),
    .wb0      (wb0),
    .wb1      (wb1),
    .wb_data0 (wb_data0),
    .wb_data1 (wb_data1)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, run went past %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // case file

  task automatic load_cases();
    int    fd;
    int    n;
    int    v0;
    int    d0;
    int    v1;
    int    d1;
    string line;
    string name;
    logic [31:0] i0;
    logic [31:0] i1;
    logic [31:0] x0;
    logic [31:0] x1;
    fd = $fopen("sim/dual_issue_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file sim/dual_issue_cases.txt");
      load_errors++;
    end else begin
      while (!$feof(fd) && n_cases < max_cases) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%s %h %h %d %d %h %d %d %h",
                      name, i0, i1, v0, d0, x0, v1, d1, x1);
          if (n == 9) begin
            case_name[n_cases]   = name;
            case_instr0[n_cases] = i0;
            case_instr1[n_cases] = i1;
            case_exp0[n_cases]   = '{valid: v0[0], dest: d0[4:0], data: x0};
            case_exp1[n_cases]   = '{valid: v1[0], dest: d1[4:0], data: x1};
            n_cases++;
          end else begin
            $display("malformed line in case file: %s", line);
            load_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drive and check

  task automatic drive_pair(input int idx);
    issue  = 1'b1;
    instr0 = case_instr0[idx];
    instr1 = case_instr1[idx];
  endtask

  task automatic drive_idle();
    issue  = 1'b0;
    // ori r1 and ori r2, kept out only by issue low
    instr0 = 32'h3401dead;
    instr1 = 32'h3402beef;
  endtask

  task automatic compare_lane(input string name, input int lane, input exp_wb_t exp,
                              input wb_t act, input logic [31:0] data, inout int bad);
    if (act.valid !== exp.valid) begin
      if (exp.valid)
        $display("%s lane %0d: expected a writeback, valid stayed low", name, lane);
      else
        $display("%s lane %0d: writeback reported where none was expected", name, lane);
      bad++;
    end else if (exp.valid) begin
      if (act.dest !== exp.dest) begin
        $display("MISMATCH %s lane %0d dest: expected %0d, actual %0d",
                 name, lane, exp.dest, act.dest);
        bad++;
      end
      if (data !== exp.data) begin
        $display("MISMATCH %s lane %0d data: expected %h, actual %h",
                 name, lane, exp.data, data);
        bad++;
      end
    end
  endtask

  task automatic check_slot(input int ci);
    int bad;
    bad = 0;
    if (ci < 0) begin
      // nothing issued two edges back
      if (wb0.valid !== 1'b0 || wb1.valid !== 1'b0) begin
        $display("writeback valid seen in an idle slot at cycle %0d", cycles);
        idle_errors++;
      end
    end else begin
      compare_lane(case_name[ci], 0, case_exp0[ci], wb0, wb_data0, bad);
      compare_lane(case_name[ci], 1, case_exp1[ci], wb1, wb_data1, bad);
      if (bad == 0) begin
        $display("case %s: ok", case_name[ci]);
        pass_count++;
      end else begin
        $display("case %s: failed", case_name[ci]);
        fail_count++;
      end
    end
  endtask

  initial begin
    int idx;
    int gap;
    int pend0;
    int pend1;
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue       = 1'b0;
    instr0      = '0;
    instr1      = '0;
    n_cases     = 0;
    pass_count  = 0;
    fail_count  = 0;
    idle_errors = 0;
    load_errors = 0;
    cycles      = 0;
    cycle_limit = 0;
    lcg_state   = 32'hf937;

    load_cases();
    cycle_limit = 3 * (n_cases * 4) + 20;

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    idx   = 0;
    gap   = 0;
    pend0 = -1;
    pend1 = -1;
    // one pass per falling edge, results checked two slots after issue
    while (idx < n_cases || pend0 >= 0 || pend1 >= 0) begin
      check_slot(pend1);
      pend1 = pend0;
      if (idx < n_cases && gap == 0) begin
        drive_pair(idx);
        pend0     = idx;
        idx++;
        lcg_state = lcg_next(lcg_state);
        gap       = (lcg_state >> 16) % 3;
      end else begin
        drive_idle();
        pend0 = -1;
        if (gap > 0) gap--;
      end
      @(negedge clk);
    end

    $display("%0d cases passed, %0d failed, %0d idle slot errors, %0d load errors",
             pass_count, fail_count, idle_errors, load_errors);
    if (fail_count == 0 && idle_errors == 0 && load_errors == 0 && n_cases > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== dual_issue_core.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/instr_decoder.sv
source/alu.sv
source/exec_lane.sv
source/register_file.sv
source/dual_issue_core.sv
sim/dual_issue_core_tb.sv

// ==== sim/dual_issue_cases.txt ====
# name instr0 instr1 valid0 dest0 data0 valid1 dest1 data1
# instr and data in hex, valid and dest in decimal, values follow in-order execution
init_ori 34011234 340200ff 1 1 00001234 1 2 000000ff
addi_pair 20038000 2004ffff 1 3 00008000 1 4 0000ffff
add_fwd 00222820 00643020 1 5 00001333 1 6 00017fff
sub_cross 00c53822 00a64022 1 7 00016ccc 1 8 fffe9334
and_or 00e84824 00e85025 1 9 00000004 1 10 fffffffc
xor_slt 00225826 0149602a 1 11 000012cb 1 12 00000001
slt_signed 012a682a 0064702a 1 13 00000000 1 14 00000001
shifts 00017900 000a8202 1 15 00012340 1 16 00ffffff
shift_fwd 000f8c00 001090c2 1 17 23400000 1 18 001fffff
andi_xori 31530f0f 3954ffff 1 19 00000f0c 1 20 ffff0003
same_dest 20150011 20150022 1 21 00000011 1 21 00000022
same_dest_read 02a0b020 02b5b825 1 22 00000022 1 23 00000022
same_dest_late 36b80100 02acc820 1 24 00000122 1 25 00000023
r0_target 00220020 20005555 0 0 00000000 0 0 00000000
r0_read 0000d025 201b0007 1 26 00000000 1 27 00000007
chain_a 037be020 037ae822 1 28 0000000e 1 29 00000007
chain_b 03bcf022 039df826 1 30 fffffff9 1 31 00000009
chain_c 03df082a 001e1102 1 1 00000001 1 2 0fffffff
overwrite_fwd 00221820 304100f0 1 3 10000000 1 1 000000f0
war_check 00232020 00612822 1 4 100000f0 1 5 0fffff10
unknown_op 0000303f fc061234 0 0 00000000 0 0 00000000
after_unknown 00c03025 20e70001 1 6 00017fff 1 7 00016ccd
sll_max 000c47c0 00144842 1 8 80000000 1 9 7fff8001
slt_neg 0109502a 0128582a 1 10 00000001 1 11 00000000
add_wrap 01086020 212dffff 1 12 00000000 1 13 80008000
dual_dest_r 01a97022 01ac7026 1 14 0000ffff 1 14 80008000
dual_dest_r_read 01c07825 01cd8024 1 15 80008000 1 16 80008000
